// File: superscalar_fetch.f
rtl/fetch_pkg.sv
rtl/fetch_bus_if.sv
rtl/early_imm_decoder.sv
rtl/branch_predictor.sv
rtl/pc_ctrl.sv
rtl/multi_fetch.sv
rtl/inst_buffer.sv
rtl/issue_stage.sv
rtl/fetch_top.sv
sim/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module fetch_tb \
   -f superscalar_fetch.f \
   -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi

// File: sim/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
   import fetch_pkg::*;

   localparam int CLK_HALF    = 2;
   // About 180 checked issues at a few cycles each under random
   // back-pressure and refills after jumps leave a wide margin
   localparam int CYCLE_LIMIT = 2000;

   logic   clk;
   logic   reset;
   addr_t  inst_addr_0;
   addr_t  inst_addr_1;
   addr_t  inst_addr_2;
   instr_t instruction_0;
   instr_t instruction_1;
   instr_t instruction_2;
   logic   update_valid;
   addr_t  update_pc;
   logic   update_taken;
   logic   flush;
   addr_t  correct_pc;
   logic   issue_valid;
   addr_t  issue_pc;
   instr_t issue_instr;
   imm_t   issue_imm;
   logic   issue_pred;
   logic   issue_ready;

   instr_t      mem     [64];
   ctr_t        ctr_ref [BHT_ENTRIES];   // Model copy of the counter table
   addr_t       exp_q   [$];
   logic [31:0] lfsr;
   logic        random_ready;
   int          errors;
   int          checks;
   int          cycles;

   fetch_top dut_i (
      .clk (clk), .reset (reset),
      .inst_addr_0_o (inst_addr_0), .inst_addr_1_o (inst_addr_1),
      .inst_addr_2_o (inst_addr_2),
      .instruction_0_i (instruction_0), .instruction_1_i (instruction_1),
      .instruction_2_i (instruction_2),
      .update_valid_i (update_valid), .update_pc_i (update_pc),
      .update_taken_i (update_taken), .flush_i (flush), .correct_pc_i (correct_pc),
      .issue_valid_o (issue_valid), .issue_pc_o (issue_pc), .issue_instr_o (issue_instr),
      .issue_imm_o (issue_imm), .issue_pred_o (issue_pred), .issue_ready_i (issue_ready)
   );

   // Word addressed memory that aliases every 256 bytes
   assign instruction_0 = mem[inst_addr_0[7:2]];
   assign instruction_1 = mem[inst_addr_1[7:2]];
   assign instruction_2 = mem[inst_addr_2[7:2]];

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // Immediates by instruction format
   function automatic imm_t imm_of(input instr_t w);
      case (w[6:0])
         OPC_LUI, OPC_AUIPC:           return {w[31:12], 12'h000};
         OPC_JAL:    return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
         OPC_BRANCH: return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
         OPC_STORE:  return 32'($signed({w[31:25], w[11:7]}));
         OPC_JALR, OPC_LOAD, OPC_OP_IMM: return 32'($signed(w[31:20]));
         default:    return '0;
      endcase
   endfunction

   function automatic instr_t addi_word(input logic [4:0] rd, input logic [11:0] imm);
      return {imm, 5'd0, 3'b000, rd, OPC_OP_IMM};
   endfunction

   function automatic instr_t jal_word(input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
   endfunction

   function automatic instr_t beq_word(input logic [12:0] off);
      return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], OPC_BRANCH};
   endfunction

   function automatic logic pred_of(input addr_t pc);
      instr_t w;
      w = mem[pc[7:2]];
      return w[6:0] == OPC_JAL || (w[6:0] == OPC_BRANCH && ctr_ref[pc[5:2]][1]);
   endfunction

   function automatic addr_t next_pc_of(input addr_t pc);
      return pred_of(pc) ? pc + imm_of(mem[pc[7:2]]) : pc + 32'd4;
   endfunction

   task automatic next_cycle();
      @(negedge clk);
      if (random_ready) begin
         lfsr = lfsr_next(lfsr);
         issue_ready = lfsr[0];
      end else begin
         issue_ready = 1'b1;
      end
   endtask

   task automatic build_expected(input addr_t start, input int n);
      addr_t pc;
      pc = start;
      for (int i = 0; i < n; i++) begin
         exp_q.push_back(pc);
         pc = next_pc_of(pc);
      end
   endtask

   task automatic restart(input addr_t start, input int n);
      @(negedge clk);
      issue_ready = 1'b0;   // Nothing leaves on the flush edge
      flush       = 1'b1;
      correct_pc  = start;
      exp_q.delete();
      next_cycle();
      flush = 1'b0;
      build_expected(start, n);
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0)
         next_cycle();
   endtask

   task automatic train_branch(input addr_t pc, input logic taken);
      next_cycle();
      update_valid = 1'b1;
      update_pc    = pc;
      update_taken = taken;
      next_cycle();
      update_valid = 1'b0;
      if (taken && ctr_ref[pc[5:2]] != 2'b11)
         ctr_ref[pc[5:2]] = ctr_ref[pc[5:2]] + 2'd1;
      else if (!taken && ctr_ref[pc[5:2]] != 2'b00)
         ctr_ref[pc[5:2]] = ctr_ref[pc[5:2]] - 2'd1;
   endtask

   // Distinct ADDI immediates built from the tag and the word index
   task automatic fill_addi(input logic [5:0] tag);
      for (int i = 0; i < 64; i++)
         mem[i] = addi_word(5'(i), {tag, 6'(i)});
   endtask

   always @(posedge clk) begin
      addr_t exp_pc;
      if (reset && issue_valid && issue_ready && exp_q.size() != 0) begin
         exp_pc = exp_q.pop_front();
         checks++;
         assert (issue_pc == exp_pc) else begin
            $display("mismatch at %0t: pc expected %h, got %h", $time, exp_pc, issue_pc);
            errors++;
         end
         assert (issue_instr == mem[exp_pc[7:2]]) else begin
            $display("mismatch at %0t: word at %h expected %h, got %h", $time, exp_pc,
                     mem[exp_pc[7:2]], issue_instr);
            errors++;
         end
         assert (issue_imm == imm_of(mem[exp_pc[7:2]])) else begin
            $display("mismatch at %0t: imm at %h expected %h, got %h", $time, exp_pc,
                     imm_of(mem[exp_pc[7:2]]), issue_imm);
            errors++;
         end
         assert (issue_pred == pred_of(exp_pc)) else begin
            $display("mismatch at %0t: prediction at %h expected %b, got %b", $time,
                     exp_pc, pred_of(exp_pc), issue_pred);
            errors++;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, %0d issues never arrived", cycles, exp_q.size());
         $display("Checks: %0d, errors: %0d", checks, errors);
         $display("Done: errors found");
         $finish;
      end
   end

   initial begin
      reset        = 1'b0;
      flush        = 1'b0;
      correct_pc   = RESET_PC;
      update_valid = 1'b0;
      update_pc    = '0;
      update_taken = 1'b0;
      issue_ready  = 1'b0;
      random_ready = 1'b0;
      lfsr         = 32'ha3e2;
      errors       = 0;
      checks       = 0;
      cycles       = 0;
      for (int i = 0; i < BHT_ENTRIES; i++)
         ctr_ref[i] = CTR_INIT;
      fill_addi(6'h05);
      repeat (5) @(posedge clk);
      @(negedge clk);
      assert (!issue_valid && inst_addr_0 == RESET_PC && inst_addr_1 == RESET_PC + 32'd4
              && inst_addr_2 == RESET_PC + 32'd8) else begin
         $display("mismatch at %0t: after reset valid %b, addresses %h %h %h", $time,
                  issue_valid, inst_addr_0, inst_addr_1, inst_addr_2);
         errors++;
      end
      reset       = 1'b1;
      issue_ready = 1'b1;
      build_expected(RESET_PC, 24);   // Straight-line run out of reset
      wait_drained();

      fill_addi(6'h11);
      mem[1]  = jal_word(21'h00003c);   // Slot 1 jump from 0x04 to 0x40
      mem[16] = jal_word(21'h000040);   // Slot 0 jump from 0x40 to 0x80
      restart(RESET_PC, 20);
      wait_drained();

      fill_addi(6'h22);                 // Negative ADDI immediates
      mem[4] = beq_word(13'h0020);      // 0x10 to 0x30
      restart(RESET_PC, 12);
      wait_drained();
      train_branch(32'h10, 1'b1);
      train_branch(32'h10, 1'b1);
      restart(RESET_PC, 12);
      wait_drained();

      // Mixed program under random back-pressure
      fill_addi(6'h2d);
      mem[3]  = jal_word(21'h000028);   // 0x0c to 0x34
      mem[5]  = {20'habcde, 5'd3, OPC_LUI};
      mem[6]  = {12'h010, 5'd1, 3'b000, 5'd0, OPC_JALR};
      mem[7]  = {7'h7f, 5'd2, 5'd1, 3'b010, 5'h15, OPC_STORE};
      mem[16] = beq_word(13'h1fd0);     // Back to 0x10 while its counter is still weak
      mem[20] = beq_word(13'h0020);     // Shares the trained counter
      random_ready = 1'b1;
      restart(32'h10, 60);
      wait_drained();

      restart(RESET_PC, 40);
      while (exp_q.size() > 25)
         next_cycle();
      restart(32'h14, 20);              // Flush in the middle of the stream
      wait_drained();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
   input  logic               clk,
   input  logic               reset,
   output fetch_pkg::addr_t   inst_addr_0_o,
   output fetch_pkg::addr_t   inst_addr_1_o,
   output fetch_pkg::addr_t   inst_addr_2_o,
   input  fetch_pkg::instr_t  instruction_0_i,
   input  fetch_pkg::instr_t  instruction_1_i,
   input  fetch_pkg::instr_t  instruction_2_i,
   input  logic               update_valid_i,
   input  fetch_pkg::addr_t   update_pc_i,
   input  logic               update_taken_i,
   input  logic               flush_i,
   input  fetch_pkg::addr_t   correct_pc_i,
   output logic               issue_valid_o,
   output fetch_pkg::addr_t   issue_pc_o,
   output fetch_pkg::instr_t  issue_instr_o,
   output fetch_pkg::imm_t    issue_imm_o,
   output logic               issue_pred_o,
   input  logic               issue_ready_i
);
   import fetch_pkg::*;

   addr_t  inst_addr   [FETCH_WIDTH];
   instr_t instruction [FETCH_WIDTH];

   logic   buf_valid;
   addr_t  buf_pc;
   instr_t buf_instr;
   imm_t   buf_imm;
   logic   buf_pred;
   logic   buf_pop;

   fetch_bus_if fb ();

   assign inst_addr_0_o  = inst_addr[0];
   assign inst_addr_1_o  = inst_addr[1];
   assign inst_addr_2_o  = inst_addr[2];
   assign instruction[0] = instruction_0_i;
   assign instruction[1] = instruction_1_i;
   assign instruction[2] = instruction_2_i;

   multi_fetch u_fetch (
      .clk            (clk),
      .reset          (reset),
      .inst_addr_o    (inst_addr),
      .instruction_i  (instruction),
      .flush_i        (flush_i),
      .correct_pc_i   (correct_pc_i),
      .update_valid_i (update_valid_i),
      .update_pc_i    (update_pc_i),
      .update_taken_i (update_taken_i),
      .fb             (fb.producer)
   );

   inst_buffer u_buffer (
      .clk         (clk),
      .reset       (reset),
      .flush_i     (flush_i),
      .fb          (fb.buffer),
      .out_valid_o (buf_valid),
      .out_pc_o    (buf_pc),
      .out_instr_o (buf_instr),
      .out_imm_o   (buf_imm),
      .out_pred_o  (buf_pred),
      .out_pop_i   (buf_pop)
   );

   issue_stage u_issue (
      .clk           (clk),
      .reset         (reset),
      .flush_i       (flush_i),
      .in_valid_i    (buf_valid),
      .in_pc_i       (buf_pc),
      .in_instr_i    (buf_instr),
      .in_imm_i      (buf_imm),
      .in_pred_i     (buf_pred),
      .in_pop_o      (buf_pop),
      .issue_ready_i (issue_ready_i),
      .issue_valid_o (issue_valid_o),
      .issue_pc_o    (issue_pc_o),
      .issue_instr_o (issue_instr_o),
      .issue_imm_o   (issue_imm_o),
      .issue_pred_o  (issue_pred_o)
   );

endmodule

// File: rtl/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
   input  logic               clk,
   input  logic               reset,
   input  logic               flush_i,
   input  logic               in_valid_i,
   input  fetch_pkg::addr_t   in_pc_i,
   input  fetch_pkg::instr_t  in_instr_i,
   input  fetch_pkg::imm_t    in_imm_i,
   input  logic               in_pred_i,
   output logic               in_pop_o,
   input  logic               issue_ready_i,
   output logic               issue_valid_o,
   output fetch_pkg::addr_t   issue_pc_o,
   output fetch_pkg::instr_t  issue_instr_o,
   output fetch_pkg::imm_t    issue_imm_o,
   output logic               issue_pred_o
);

   // Take a new entry when empty or when the current one leaves this edge
   assign in_pop_o = in_valid_i & (~issue_valid_o | issue_ready_i);

   always_ff @(posedge clk or negedge reset) begin
      if (!reset)
         issue_valid_o <= 1'b0;
      else if (flush_i)
         issue_valid_o <= 1'b0;
      else if (in_pop_o)
         issue_valid_o <= 1'b1;
      else if (issue_ready_i)
         issue_valid_o <= 1'b0;   // Drained with nothing behind it
   end

   always_ff @(posedge clk) begin
      if (in_pop_o) begin
         issue_pc_o    <= in_pc_i;
         issue_instr_o <= in_instr_i;
         issue_imm_o   <= in_imm_i;
         issue_pred_o  <= in_pred_i;
      end
   end

endmodule

// File: rtl/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer (
   input  logic                clk,
   input  logic                reset,
   input  logic                flush_i,
   fetch_bus_if.buffer         fb,
   output logic                out_valid_o,
   output fetch_pkg::addr_t    out_pc_o,
   output fetch_pkg::instr_t   out_instr_o,
   output fetch_pkg::imm_t     out_imm_o,
   output logic                out_pred_o,
   input  logic                out_pop_i
);
   import fetch_pkg::*;

   addr_t    pc_mem    [BUF_DEPTH];
   instr_t   instr_mem [BUF_DEPTH];
   imm_t     imm_mem   [BUF_DEPTH];
   logic     pred_mem  [BUF_DEPTH];

   buf_ptr_t head_q;
   buf_ptr_t tail_q;
   buf_cnt_t count_q;

   buf_ptr_t               wr_idx [FETCH_WIDTH];
   logic [FETCH_WIDTH-1:0] wr_en;
   buf_cnt_t               push_cnt;
   logic                   pop;

   // Only accept when a full group is guaranteed to fit
   assign fb.ready    = count_q <= buf_cnt_t'(BUF_DEPTH - FETCH_WIDTH);
   assign out_valid_o = count_q != '0;
   assign pop         = out_pop_i & out_valid_o;

   // Pack valid slots in order behind the tail
   always_comb begin
      push_cnt = '0;
      for (int i = 0; i < FETCH_WIDTH; i++) begin
         wr_en[i]  = fb.valid[i] & fb.ready;
         wr_idx[i] = tail_q + buf_ptr_t'(push_cnt);
         push_cnt  = push_cnt + buf_cnt_t'(wr_en[i]);
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < FETCH_WIDTH; i++) begin
         if (wr_en[i]) begin
            pc_mem[wr_idx[i]]    <= fb.pc[i];
            instr_mem[wr_idx[i]] <= fb.instr[i];
            imm_mem[wr_idx[i]]   <= fb.imm[i];
            pred_mem[wr_idx[i]]  <= fb.pred_taken[i];
         end
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end else if (flush_i) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end else begin
         head_q  <= head_q + buf_ptr_t'(pop);
         tail_q  <= tail_q + buf_ptr_t'(push_cnt);   // Pointers wrap on their own
         count_q <= count_q + push_cnt - buf_cnt_t'(pop);
      end
   end

   assign out_pc_o    = pc_mem[head_q];
   assign out_instr_o = instr_mem[head_q];
   assign out_imm_o   = imm_mem[head_q];
   assign out_pred_o  = pred_mem[head_q];

endmodule

// File: rtl/multi_fetch.sv
`timescale 1ns/1ps

module multi_fetch (
   input  logic                 clk,
   input  logic                 reset,
   output fetch_pkg::addr_t     inst_addr_o   [fetch_pkg::FETCH_WIDTH],
   input  fetch_pkg::instr_t    instruction_i [fetch_pkg::FETCH_WIDTH],
   input  logic                 flush_i,
   input  fetch_pkg::addr_t     correct_pc_i,
   input  logic                 update_valid_i,
   input  fetch_pkg::addr_t     update_pc_i,
   input  logic                 update_taken_i,
   fetch_bus_if.producer        fb
);
   import fetch_pkg::*;

   addr_t                  pc   [FETCH_WIDTH];
   imm_t                   imm  [FETCH_WIDTH];
   logic [FETCH_WIDTH-1:0] taken;
   logic [FETCH_WIDTH-1:0] slot_valid;

   for (genvar g = 0; g < FETCH_WIDTH; g++) begin : g_dec
      early_imm_decoder u_imm_dec (
         .instr_i (instruction_i[g]),
         .imm_o   (imm[g])
      );
   end

   branch_predictor u_bp (
      .clk            (clk),
      .reset          (reset),
      .pc_i           (pc),
      .instr_i        (instruction_i),
      .update_valid_i (update_valid_i),
      .update_pc_i    (update_pc_i),
      .update_taken_i (update_taken_i),
      .taken_o        (taken)
   );

   pc_ctrl u_pc_ctrl (
      .clk           (clk),
      .reset         (reset),
      .advance_i     (fb.ready),    // Stall whenever the buffer lacks room
      .taken_i       (taken),
      .imm_i         (imm),
      .redirect_i    (flush_i),
      .redirect_pc_i (correct_pc_i),
      .pc_o          (pc)
   );

   assign inst_addr_o = pc;

   // Drop every slot behind a predicted-taken one
   always_comb begin
      logic kill;
      kill = 1'b0;
      for (int i = 0; i < FETCH_WIDTH; i++) begin
         slot_valid[i] = ~kill;
         kill = kill | taken[i];
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset)
         fb.valid <= '0;
      else if (flush_i)
         fb.valid <= '0;
      else if (fb.ready)
         fb.valid <= slot_valid;
   end

   always_ff @(posedge clk) begin
      if (fb.ready) begin
         fb.pc         <= pc;
         fb.instr      <= instruction_i;
         fb.imm        <= imm;
         fb.pred_taken <= taken;
      end
   end

endmodule

// File: rtl/pc_ctrl.sv
`timescale 1ns/1ps

module pc_ctrl (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              advance_i,
   input  logic [fetch_pkg::FETCH_WIDTH-1:0] taken_i,
   input  fetch_pkg::imm_t                   imm_i [fetch_pkg::FETCH_WIDTH],
   input  logic                              redirect_i,
   input  fetch_pkg::addr_t                  redirect_pc_i,
   output fetch_pkg::addr_t                  pc_o  [fetch_pkg::FETCH_WIDTH]
);
   import fetch_pkg::*;

   addr_t base_q;
   addr_t next_pc;

   // Slots sit one word apart from the base
   always_comb begin
      for (int i = 0; i < FETCH_WIDTH; i++)
         pc_o[i] = base_q + addr_t'(4 * i);
   end

   // Walk from the last slot down so the first taken slot wins
   always_comb begin
      next_pc = base_q + addr_t'(4 * FETCH_WIDTH);
      for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
         if (taken_i[i])
            next_pc = pc_o[i] + imm_i[i];
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset)
         base_q <= RESET_PC;
      else if (redirect_i)
         base_q <= redirect_pc_i;   // Back end correction has priority
      else if (advance_i)
         base_q <= next_pc;
   end

endmodule

// File: rtl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
   input  logic                                 clk,
   input  logic                                 reset,
   input  fetch_pkg::addr_t                     pc_i    [fetch_pkg::FETCH_WIDTH],
   input  fetch_pkg::instr_t                    instr_i [fetch_pkg::FETCH_WIDTH],
   input  logic                                 update_valid_i,
   input  fetch_pkg::addr_t                     update_pc_i,
   input  logic                                 update_taken_i,
   output logic [fetch_pkg::FETCH_WIDTH-1:0]    taken_o
);
   import fetch_pkg::*;

   ctr_t     bht_q [BHT_ENTRIES];
   bht_idx_t upd_idx;

   assign upd_idx = update_pc_i[BHT_IDX_W+1:2];

   // Per-slot decision, reads the table as it stood before this edge
   always_comb begin
      for (int i = 0; i < FETCH_WIDTH; i++) begin
         bht_idx_t rd_idx;
         rd_idx = pc_i[i][BHT_IDX_W+1:2];
         if (instr_i[i][6:0] == OPC_JAL)
            taken_o[i] = 1'b1;             // JAL always taken
         else if (instr_i[i][6:0] == OPC_BRANCH)
            taken_o[i] = bht_q[rd_idx][1];
         else
            taken_o[i] = 1'b0;             // JALR and the rest fall through
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < BHT_ENTRIES; i++)
            bht_q[i] <= CTR_INIT;
      end else if (update_valid_i) begin
         if (update_taken_i && bht_q[upd_idx] != 2'b11)
            bht_q[upd_idx] <= bht_q[upd_idx] + 2'd1;
         else if (!update_taken_i && bht_q[upd_idx] != 2'b00)
            bht_q[upd_idx] <= bht_q[upd_idx] - 2'd1;
      end
   end

endmodule

// File: rtl/early_imm_decoder.sv
`timescale 1ns/1ps

module early_imm_decoder (
   input  fetch_pkg::instr_t instr_i,
   output fetch_pkg::imm_t   imm_o
);
   import fetch_pkg::*;

   opcode_t opcode;

   assign opcode = instr_i[6:0];

   always_comb begin
      case (opcode)
         // U format, upper 20 bits
         OPC_LUI, OPC_AUIPC:
            imm_o = {instr_i[31:12], 12'b0};
         OPC_JAL:
            imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};
         OPC_BRANCH:
            imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
         OPC_STORE:
            imm_o = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
         // I format
         OPC_JALR, OPC_LOAD, OPC_OP_IMM:
            imm_o = {{21{instr_i[31]}}, instr_i[30:20]};
         default:
            imm_o = '0; // R-type and anything without an immediate
      endcase
   end

endmodule

// File: rtl/fetch_bus_if.sv
`timescale 1ns/1ps

interface fetch_bus_if;
   import fetch_pkg::*;

   logic [FETCH_WIDTH-1:0] valid;      // One bit per slot
   addr_t                  pc    [FETCH_WIDTH];
   instr_t                 instr [FETCH_WIDTH];
   imm_t                   imm   [FETCH_WIDTH];
   logic [FETCH_WIDTH-1:0] pred_taken;
   logic                   ready;      // Room for a whole group

   modport producer (
      output valid, pc, instr, imm, pred_taken,
      input  ready
   );

   modport buffer (
      input  valid, pc, instr, imm, pred_taken,
      output ready
   );

endinterface

// File: rtl/fetch_pkg.sv
package fetch_pkg;

   // Group and storage sizes
   localparam int FETCH_WIDTH = 3;
   localparam int BUF_DEPTH   = 8;
   localparam int BHT_ENTRIES = 16;
   localparam int BUF_PTR_W   = $clog2(BUF_DEPTH);
   localparam int BHT_IDX_W   = $clog2(BHT_ENTRIES);

   typedef logic [31:0]          addr_t;
   typedef logic [31:0]          instr_t;
   typedef logic [31:0]          imm_t;
   typedef logic [1:0]           ctr_t;    // Saturating branch counter
   typedef logic [6:0]           opcode_t;
   typedef logic [BUF_PTR_W-1:0] buf_ptr_t;
   typedef logic [BUF_PTR_W:0]   buf_cnt_t; // One extra bit so a full buffer fits
   typedef logic [BHT_IDX_W-1:0] bht_idx_t;

   localparam addr_t  RESET_PC  = 32'h0000_0000;
   localparam instr_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0
   localparam ctr_t   CTR_INIT  = 2'd1;          // Weakly not taken

   // Opcodes with an immediate the front end cares about
   localparam opcode_t OPC_JAL    = 7'b1101111;
   localparam opcode_t OPC_JALR   = 7'b1100111;
   localparam opcode_t OPC_BRANCH = 7'b1100011;
   localparam opcode_t OPC_LUI    = 7'b0110111;
   localparam opcode_t OPC_AUIPC  = 7'b0010111;
   localparam opcode_t OPC_STORE  = 7'b0100011;
   localparam opcode_t OPC_LOAD   = 7'b0000011;
   localparam opcode_t OPC_OP_IMM = 7'b0010011;

endpackage
